/* rtl/mem_bus_pkg.sv */
// --------------------
// data widths and port structs for the
// processor side and the line-wide memory side
// --------------------
`default_nettype none

package mem_bus_pkg;

	// ---- base types ----
	typedef logic [31:0]  word_t;
	typedef logic [29:0]  word_addr_t;
	// word address without the word offset
	typedef logic [27:0]  block_addr_t;
	// four words, word 0 in the low bits
	typedef logic [127:0] line_t;

	// ---- processor port ----
	typedef struct packed {
		logic       read;
		logic       write;
		word_addr_t addr;
		word_t      wdata;
	} proc_req_t;

	typedef struct packed {
		logic  stall;
		word_t rdata;
	} proc_rsp_t;

	// ---- memory port ----
	typedef struct packed {
		logic        read;
		logic        write;
		block_addr_t addr;
		line_t       wdata;
	} mem_req_t;

	typedef struct packed {
		logic  ready;
		line_t rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* rtl/cache_pkg.sv */
// --------------------
// cache geometry constants, controller states
// and the command and status structs of a way
// --------------------
`default_nettype none

package cache_pkg;

	// ---- line geometry ----
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_BITS    = 2;

	// ---- controller states ----
	typedef enum logic [1:0] {
		idle       = 2'd0,
		compare    = 2'd1,
		write_back = 2'd2,
		allocate   = 2'd3
	} cache_state_t;

	// ---- controller to way ----
	// all commands act on the set picked by the address
	typedef struct packed {
		// store line and tag, set valid, clear dirty
		logic               fill;
		// replace the addressed word, set dirty
		logic               write_word;
		// victim line is now in memory
		logic               clean;
		mem_bus_pkg::word_t word;
		mem_bus_pkg::line_t line;
	} way_cmd_t;

	// ---- way to controller ----
	typedef struct packed {
		logic                     hit;
		logic                     dirty;
		// word at the address offset
		mem_bus_pkg::word_t       word;
		// whole stored line, used for write-back
		mem_bus_pkg::line_t       line;
		// stored tag joined with the set
		mem_bus_pkg::block_addr_t victim_addr;
	} way_status_t;

endpackage

`default_nettype wire

/* rtl/cache_way.sv */
// --------------------
// one cache way with valid, dirty, tag and line per set
// --------------------
`timescale 1ns/10ps
`default_nettype none

module cache_way #(
	parameter int num_sets = 4
) (
	input  logic                    clk,
	input  logic                    proc_reset,
	input  mem_bus_pkg::word_addr_t addr,
	input  cache_pkg::way_cmd_t     cmd,
	output cache_pkg::way_status_t  status
);
	import mem_bus_pkg::*;
	import cache_pkg::*;

	localparam int set_bits  = $clog2(num_sets);
	localparam int tag_bits  = $bits(word_addr_t) - OFFSET_BITS - set_bits;
	localparam int word_bits = $bits(word_t);

	// ---- storage ----
	logic [num_sets-1:0] valid;
	logic [num_sets-1:0] dirty;
	logic [tag_bits-1:0] tag_mem [num_sets];
	line_t               line_mem [num_sets];

	// ---- address fields ----
	logic [OFFSET_BITS-1:0] offset;
	logic [set_bits-1:0]    set_idx;
	logic [tag_bits-1:0]    tag;

	line_t cur_line;
	line_t merged_line;

	assign offset  = addr[OFFSET_BITS-1:0];
	assign set_idx = addr[OFFSET_BITS +: set_bits];
	assign tag     = addr[$bits(word_addr_t)-1 -: tag_bits];

	assign cur_line = line_mem[set_idx];

	// stored line with the addressed word swapped for the write data
	always_comb begin
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			if (w == int'(offset)) begin
				merged_line[w*word_bits +: word_bits] = cmd.word;
			end else begin
				merged_line[w*word_bits +: word_bits] = cur_line[w*word_bits +: word_bits];
			end
		end
	end

	// ---- status ----
	// purely combinational from address and stored state
	always_comb begin
		status.hit         = valid[set_idx] & (tag_mem[set_idx] == tag);
		status.dirty       = dirty[set_idx];
		status.word        = cur_line[int'(offset)*word_bits +: word_bits];
		status.line        = cur_line;
		status.victim_addr = {tag_mem[set_idx], set_idx};
	end

	// ---- control bits ----
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (cmd.fill) begin
			valid[set_idx] <= 1'b1;
			dirty[set_idx] <= 1'b0;
		end else if (cmd.write_word) begin
			dirty[set_idx] <= 1'b1;
		end else if (cmd.clean) begin
			dirty[set_idx] <= 1'b0;
		end
	end

	// ---- tag and data ----
	always_ff @(posedge clk) begin
		if (cmd.fill) begin
			tag_mem[set_idx]  <= tag;
			line_mem[set_idx] <= cmd.line;
		end else if (cmd.write_word) begin
			// tag already matches on a write hit
			line_mem[set_idx] <= merged_line;
		end
	end

endmodule

`default_nettype wire

/* rtl/dcache_ctrl.sv */
// --------------------
// miss FSM, per-set LRU, hit combining
// and memory request generation
// --------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl #(
	parameter int num_sets = 4
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  mem_bus_pkg::proc_req_t proc_req,
	output mem_bus_pkg::proc_rsp_t proc_rsp,
	input  cache_pkg::way_status_t status0,
	input  cache_pkg::way_status_t status1,
	output cache_pkg::way_cmd_t    cmd0,
	output cache_pkg::way_cmd_t    cmd1,
	output mem_bus_pkg::mem_req_t  mem_req,
	input  mem_bus_pkg::mem_rsp_t  mem_rsp
);
	import mem_bus_pkg::*;
	import cache_pkg::*;

	localparam int set_bits = $clog2(num_sets);

	cache_state_t state;
	cache_state_t state_next;

	// lru bit names the way to replace next
	logic [num_sets-1:0] lru;
	logic [num_sets-1:0] lru_next;

	logic  mem_ready_q;
	line_t mem_rdata_q;

	logic [set_bits-1:0] set_idx;
	block_addr_t         block_addr;
	logic                req_active;
	logic                hit;
	logic                cmp_hit;
	logic                victim_sel;
	way_status_t         victim;

	logic do_write;
	logic do_clean;
	logic do_fill;

	// ---- decode ----
	assign set_idx    = proc_req.addr[OFFSET_BITS +: set_bits];
	assign block_addr = proc_req.addr[$bits(word_addr_t)-1:OFFSET_BITS];
	assign req_active = proc_req.read | proc_req.write;
	assign hit        = status0.hit | status1.hit;
	assign cmp_hit    = (state == compare) & req_active & hit;
	assign victim_sel = lru[set_idx];
	assign victim     = victim_sel ? status1 : status0;

	// ---- next state ----
	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				state_next = compare;
			end
			compare: begin
				// only the chosen victim decides on write-back
				if (req_active && !hit) begin
					state_next = victim.dirty ? write_back : allocate;
				end
			end
			write_back: begin
				if (mem_ready_q) begin
					state_next = allocate;
				end
			end
			allocate: begin
				if (mem_ready_q) begin
					state_next = compare;
				end
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	// ---- lru update ----
	// a hit points the set at the other way
	always_comb begin
		lru_next = lru;
		if (cmp_hit) begin
			lru_next[set_idx] = status0.hit;
		end
	end

	// ---- processor side ----
	always_comb begin
		proc_rsp.stall = req_active & ~cmp_hit;
		proc_rsp.rdata = status0.hit ? status0.word : status1.word;
	end

	// ---- memory side ----
	// strobe drops while the registered ready is seen
	always_comb begin
		mem_req.read  = (state == allocate) & ~mem_ready_q;
		mem_req.write = (state == write_back) & ~mem_ready_q;
		mem_req.addr  = (state == write_back) ? victim.victim_addr : block_addr;
		mem_req.wdata = victim.line;
	end

	// ---- way commands ----
	assign do_write = cmp_hit & proc_req.write;
	assign do_clean = (state == write_back) & mem_ready_q;
	assign do_fill  = (state == allocate) & mem_ready_q;

	always_comb begin
		cmd0.fill       = do_fill & ~victim_sel;
		cmd0.write_word = do_write & status0.hit;
		cmd0.clean      = do_clean & ~victim_sel;
		cmd0.word       = proc_req.wdata;
		cmd0.line       = mem_rdata_q;

		cmd1.fill       = do_fill & victim_sel;
		cmd1.write_word = do_write & status1.hit;
		cmd1.clean      = do_clean & victim_sel;
		cmd1.word       = proc_req.wdata;
		cmd1.line       = mem_rdata_q;
	end

	// ---- registers ----
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state       <= idle;
			lru         <= '0;
			mem_ready_q <= 1'b0;
		end else begin
			state       <= state_next;
			lru         <= lru_next;
			mem_ready_q <= mem_rsp.ready;
		end
	end

	// memory line registered next to the ready bit
	always_ff @(posedge clk) begin
		mem_rdata_q <= mem_rsp.rdata;
	end

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
// --------------------
// two-way data cache top with both ways and the controller
// --------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
	parameter int num_sets = 4
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  mem_bus_pkg::proc_req_t proc_req,
	output mem_bus_pkg::proc_rsp_t proc_rsp,
	output mem_bus_pkg::mem_req_t  mem_req,
	input  mem_bus_pkg::mem_rsp_t  mem_rsp
);
	import cache_pkg::*;

	way_cmd_t    cmd0;
	way_cmd_t    cmd1;
	way_status_t status0;
	way_status_t status1;

	// ---- ways ----
	// both look up the same address in parallel
	cache_way #(
		.num_sets   (num_sets)
	) i_way0 (
		.clk        (clk),
		.proc_reset (proc_reset),
		.addr       (proc_req.addr),
		.cmd        (cmd0),
		.status     (status0)
	);

	cache_way #(
		.num_sets   (num_sets)
	) i_way1 (
		.clk        (clk),
		.proc_reset (proc_reset),
		.addr       (proc_req.addr),
		.cmd        (cmd1),
		.status     (status1)
	);

	// ---- controller ----
	dcache_ctrl #(
		.num_sets   (num_sets)
	) i_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rsp   (proc_rsp),
		.status0    (status0),
		.status1    (status1),
		.cmd0       (cmd0),
		.cmd1       (cmd1),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

endmodule

`default_nettype wire

/* verification/clk_gen.sv */
// --------------------
// testbench clock and power-on reset
// --------------------
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic proc_reset
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period_ns / 2) clk = ~clk;
		end
	end

	// released on the edge that ends the last reset cycle
	initial begin
		proc_reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		proc_reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* verification/dcache_properties.sv */
// --------------------
// concurrent checks on the cache controller
// memory strobes against stall and reset
// --------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_properties (
	input logic                   clk,
	input logic                   proc_reset,
	input mem_bus_pkg::proc_rsp_t proc_rsp,
	input mem_bus_pkg::mem_req_t  mem_req
);

	logic strobe;

	assign strobe = mem_req.read | mem_req.write;

	// one line transfer at a time
	read_write_exclusive: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write)
	) else $error("memory read and write strobes are high together");

	// a memory transfer always holds the processor
	strobe_needs_stall: assert property (
		@(posedge clk) disable iff (proc_reset)
		strobe |-> proc_rsp.stall
	) else $error("memory strobe is high while stall is low");

	// idle after reset
	quiet_after_reset: assert property (
		@(posedge clk)
		proc_reset |=> !strobe
	) else $error("memory strobe is high in the cycle after reset");

endmodule

bind dcache_ctrl dcache_properties i_props (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_rsp   (proc_rsp),
	.mem_req    (mem_req)
);

`default_nettype wire

/* verification/dcache_tb.sv */
// --------------------
// data cache testbench with memory model,
// reference model, directed and random accesses
// --------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;
	import mem_bus_pkg::*;
	import cache_pkg::*;

	localparam int num_sets       = 4;
	localparam int set_bits       = $clog2(num_sets);
	localparam int access_timeout = 100;

	logic      clk;
	logic      proc_reset;
	proc_req_t proc_req;
	proc_rsp_t proc_rsp;
	mem_req_t  mem_req;
	mem_rsp_t  mem_rsp = '0;

	// reference contents and bookkeeping
	word_t       written [word_addr_t];
	line_t       mem_lines [block_addr_t];
	int          n_errors      = 0;
	int          n_reads       = 0;
	int          strobe_cycles = 0;
	int          n_mem_writes  = 0;
	block_addr_t last_wr_addr  = '0;
	line_t       last_wr_line  = '0;

	logic     mem_busy = 1'b0;
	logic     mem_hold = 1'b0;
	int       mem_wait = 0;
	mem_req_t mem_cur  = '0;

	clk_gen #(
		.period_ns    (20),
		.reset_cycles (4)
	) i_clk_gen (
		.clk        (clk),
		.proc_reset (proc_reset)
	);

	dcache_top #(
		.num_sets   (num_sets)
	) i_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rsp   (proc_rsp),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

	// ---- address and data helpers ----
	function automatic word_addr_t make_addr(input int tag, input int set, input int off);
		return word_addr_t'((tag << (OFFSET_BITS + set_bits)) | (set << OFFSET_BITS) | off);
	endfunction

	// scrambles the whole word address
	function automatic word_t init_word(input word_addr_t a);
		return (32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
	endfunction

	function automatic line_t init_line(input block_addr_t b);
		line_t l;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			l[w*$bits(word_t) +: $bits(word_t)] = init_word({b, 2'(w)});
		end
		return l;
	endfunction

	function automatic line_t read_line(input block_addr_t b);
		if (mem_lines.exists(b)) begin
			return mem_lines[b];
		end
		return init_line(b);
	endfunction

	// last value written, else what memory held from the start
	function automatic word_t expected_word(input word_addr_t a);
		if (written.exists(a)) begin
			return written[a];
		end
		return init_word(a);
	endfunction

	// ---- failure reporting ----
	task automatic report_failure(input string what);
		n_errors++;
		$display("%s", what);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		n_errors++;
		$display("error at %0t: %s = %h, expected %h", $time, name, got, want);
	endtask

	task automatic abort_run(input string what);
		report_failure(what);
		$display("reads checked: %0d, errors: %0d", n_reads, n_errors);
		$display("TB FAILED");
		$finish;
	endtask

	// one processor access, held until stall drops
	task automatic access(input logic is_write, input word_addr_t addr, input word_t data);
		int waited;
		@(posedge clk);
		proc_req.read  <= ~is_write;
		proc_req.write <= is_write;
		proc_req.addr  <= addr;
		proc_req.wdata <= data;
		waited = 0;
		@(negedge clk);
		while (proc_rsp.stall) begin
			waited++;
			if (waited > access_timeout) begin
				abort_run($sformatf("timeout at %0t: stall stayed high for address %h",
					$time, addr));
			end
			@(negedge clk);
		end
		if (is_write) begin
			written[addr] = data;
		end
		@(posedge clk);
		proc_req.read  <= 1'b0;
		proc_req.write <= 1'b0;
	endtask

	// ---- memory model ----
	// ready pulse after 1 to 5 cycles and no new strobe taken in the cycle after it
	always @(posedge clk) begin
		if (proc_reset) begin
			mem_rsp  <= '0;
			mem_busy <= 1'b0;
			mem_hold <= 1'b0;
		end else begin
			mem_rsp.ready <= 1'b0;
			if (mem_hold) begin
				mem_hold <= 1'b0;
			end else if (mem_busy) begin
				if (mem_wait == 0) begin
					mem_busy      <= 1'b0;
					mem_hold      <= 1'b1;
					mem_rsp.ready <= 1'b1;
					mem_rsp.rdata <= read_line(mem_cur.addr);
					if (mem_cur.write) begin
						mem_lines[mem_cur.addr] = mem_cur.wdata;
						n_mem_writes++;
						last_wr_addr = mem_cur.addr;
						last_wr_line = mem_cur.wdata;
					end
				end else begin
					mem_wait <= mem_wait - 1;
				end
			end else if (mem_req.read || mem_req.write) begin
				mem_busy <= 1'b1;
				mem_cur  <= mem_req;
				mem_wait <= int'($urandom_range(4, 0));
			end
		end
	end

	// ---- checking process ----
	always @(negedge clk) begin
		if (!proc_reset) begin
			if (mem_req.read || mem_req.write) begin
				strobe_cycles++;
			end
			if (proc_req.read && !proc_rsp.stall) begin
				n_reads++;
				if (proc_rsp.rdata !== expected_word(proc_req.addr)) begin
					report_mismatch("proc_rsp.rdata", proc_rsp.rdata,
						expected_word(proc_req.addr));
				end
			end
		end
	end

	// ---- stimulus ----
	initial begin
		int         waited;
		int         strobes_before;
		int         writes_before;
		int         line_idx;
		word_addr_t addr;
		word_addr_t addr_a;
		word_t      wr_data;
		word_addr_t readback[$];

		void'($urandom(84));
		proc_req = '0;
		waited   = 0;
		@(negedge clk);
		while (proc_reset !== 1'b0) begin
			waited++;
			if (waited > 20) begin
				abort_run("reset was never released");
			end
			@(negedge clk);
		end

		// idle after reset and a first read that misses
		if (proc_rsp.stall !== 1'b0) begin
			report_mismatch("proc_rsp.stall", 32'(proc_rsp.stall), 32'd0);
		end
		if (mem_req.read !== 1'b0) begin
			report_mismatch("mem_req.read", 32'(mem_req.read), 32'd0);
		end
		if (mem_req.write !== 1'b0) begin
			report_mismatch("mem_req.write", 32'(mem_req.write), 32'd0);
		end
		strobes_before = strobe_cycles;
		access(1'b0, make_addr(1, 0, 0), '0);
		if (strobe_cycles == strobes_before) begin
			report_failure($sformatf("first read at %0t caused no memory read", $time));
		end

		// same line hits and a write hit read back
		addr_a         = make_addr(1, 0, 1);
		strobes_before = strobe_cycles;
		access(1'b0, make_addr(1, 0, 2), '0);
		access(1'b1, addr_a, 32'hc0de_1234);
		access(1'b0, addr_a, '0);
		if (strobe_cycles != strobes_before) begin
			report_failure($sformatf("hits before %0t reached memory", $time));
		end

		// two more tags in set 0 push the dirty line out
		writes_before = n_mem_writes;
		access(1'b0, make_addr(2, 0, 0), '0);
		access(1'b0, make_addr(3, 0, 0), '0);
		if (n_mem_writes != writes_before + 1) begin
			report_failure($sformatf("expected one write-back before %0t, saw %0d",
				$time, n_mem_writes - writes_before));
		end
		if (last_wr_addr !== addr_a[29:OFFSET_BITS]) begin
			report_mismatch("mem_req.addr", 32'(last_wr_addr), 32'(addr_a[29:OFFSET_BITS]));
		end
		if (last_wr_line[32 +: 32] !== 32'hc0de_1234) begin
			report_mismatch("mem_req.wdata", last_wr_line[32 +: 32], 32'hc0de_1234);
		end
		access(1'b0, addr_a, '0);

		// lru order in set 1
		access(1'b0, make_addr(4, 1, 0), '0);
		access(1'b0, make_addr(5, 1, 0), '0);
		access(1'b0, make_addr(4, 1, 3), '0);
		access(1'b0, make_addr(6, 1, 0), '0);
		strobes_before = strobe_cycles;
		access(1'b0, make_addr(4, 1, 1), '0);
		if (strobe_cycles != strobes_before) begin
			report_failure($sformatf("re-read of the recently used tag missed at %0t", $time));
		end

		// random mix over 16 lines in four sets
		for (int i = 0; i < 200; i++) begin
			line_idx = int'($urandom_range(15, 0));
			addr     = make_addr(8 + line_idx / 4, line_idx % 4, int'($urandom_range(3, 0)));
			wr_data  = $urandom();
			if ($urandom_range(1, 0) == 1) begin
				access(1'b1, addr, wr_data);
			end else begin
				access(1'b0, addr, '0);
			end
		end
		foreach (written[a]) begin
			readback.push_back(a);
		end
		foreach (readback[i]) begin
			access(1'b0, readback[i], '0);
		end

		repeat (2) @(posedge clk);
		$display("reads checked: %0d, errors: %0d", n_reads, n_errors);
		if (n_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
rtl/mem_bus_pkg.sv
rtl/cache_pkg.sv
rtl/cache_way.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/clk_gen.sv
verification/dcache_properties.sv
verification/dcache_tb.sv

/* Makefile */
TOP := dcache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" sim.log; then echo "simulation did not finish"; exit 1; fi

lint:
	verilator --lint-only -Wall --top-module dcache_top \
		rtl/mem_bus_pkg.sv rtl/cache_pkg.sv rtl/cache_way.sv \
		rtl/dcache_ctrl.sv rtl/dcache_top.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log
